//--- files.f
+incdir+include
source/cipher_pkg.sv
source/cipher_config.sv
source/cipher_round_core.sv
source/cipher_top.sv
bench/cipher_properties.sv
bench/cipher_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the cipher testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module cipher_tb -f files.f -o cipher_sim

./obj_dir/cipher_sim | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -q "Finished with no errors" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"

//--- bench/cipher_stimulus.txt
# W addr data | R addr expected | P stall cycles for the next block
# B plaintext key expected_ciphertext, all fields in hex
R 0 0008
R 1 0002
R 2 0000
# Reset settings, 8 rounds with a 2-byte rotate
B 0f1e2d3c4b5a69788796a5b4c3d2e1f0 80000000000000000000000000001234 9d2abf08d96efb4c15a2378051e673c4
B 9d2abf08d96efb4c15a2378051e673c4 80000000000000000000000000001234 0f1e2d3c4b5a69788796a5b4c3d2e1f0
R 2 0002
P 6
B 0f1e2d3c4b5a69788796a5b4c3d2e1f0 80000000000000000000000000001234 9d2abf08d96efb4c15a2378051e673c4
# Three rounds without rotate
W 0 0003
W 1 0000
R 0 0003
R 1 0000
B ffffffffffffffffffffffffffffffff 0123456789abcdeffedcba9876543210 fedcba98765432100123456789abcdef
# Round count 0 is stored as 1
W 0 0000
R 0 0001
W 1 0005
R 1 0005
B 00000000000000000000000000000000 deadbeefcafef00d0123456789abcdef deadbeefcafef00d0123456789abcdef
# Three rounds with a 4-byte rotate
W 0 0003
W 1 0004
P 3
B 0000000000000000ffffffffffffffff 11223344000000000000000055667788 444444cc444444cceeddccbbaa998877
# Fifteen rounds, rotate keeps the low 4 bits
W 0 000f
W 1 001f
R 1 000f
B 0123456789abcdeffedcba9876543210 0000000000000000000000000000005a 01791f3dd3f197b5a486e0c22c0e684a
B 01791f3dd3f197b5a486e0c22c0e684a 0000000000000000000000000000005a 0123456789abcdeffedcba9876543210
# Block count ignores writes
W 2 1234
R 2 0008
W 0 0010
R 0 0001
W 0 0008
W 1 0002
B 0f1e2d3c4b5a69788796a5b4c3d2e1f0 80000000000000000000000000001234 9d2abf08d96efb4c15a2378051e673c4
R 2 0009

//--- bench/cipher_tb.sv
// Testbench of the block cipher engine
// Stimulus file reader, handshake drivers, result checks and watchdog

`timescale 1ns/10ps
`default_nettype none

`include "cipher_cfg.svh"

module cipher_tb;

    import cipher_pkg::*;

    localparam int          CLK_HALF      = 50;
    localparam int          RESET_CYCLES  = 3;
    localparam int          CYCLES_PER_OP = 40;
    localparam logic [31:0] RAND_SEED     = 32'hd8904793;
    localparam string       STIM_FILE     = "bench/cipher_stimulus.txt";

    logic          clk;
    logic          rst;
    logic          in_valid;
    logic          in_ready;
    cipher_block_t plaintext;
    cipher_block_t key;
    logic          out_valid;
    logic          out_ready;
    cipher_block_t ciphertext;
    logic          cfg_write;
    logic          cfg_read;
    cfg_addr_t     cfg_addr;
    cfg_word_t     cfg_wdata;
    cfg_word_t     cfg_rdata;

    // Operations from the stimulus file
    byte           op_code [$];
    cipher_block_t op_arg0 [$];
    cipher_block_t op_arg1 [$];
    cipher_block_t op_arg2 [$];

    logic          stim_loaded;
    int            error_count;
    int            handshakes;
    int            model_rounds;
    int            stall_cycles;

    cipher_top cipher_top_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ciphertext (ciphertext),
        .cfg_write  (cfg_write),
        .cfg_read   (cfg_read),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    bind cipher_round_core cipher_properties cipher_properties_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ciphertext (ciphertext),
        .rounds     (rounds)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string name,
                               input logic [`CIPHER_BLOCK_BITS-1:0] actual,
                               input logic [`CIPHER_BLOCK_BITS-1:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic load_stimulus();
        int            fd;
        int            status;
        string         line;
        byte           code;
        cipher_block_t a;
        cipher_block_t b;
        cipher_block_t c;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            $display("Finished with errors");
            $fatal(1, "No stimulus");
        end else begin
            while (!$feof(fd)) begin
                line   = "";
                status = $fgets(line, fd);
                // Skip blank lines and comments
                if (status > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code   = line.getc(0);
                    a      = '0;
                    b      = '0;
                    c      = '0;
                    status = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
                    op_code.push_back(code);
                    op_arg0.push_back(a);
                    op_arg1.push_back(b);
                    op_arg2.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_register(input cipher_block_t addr, input cipher_block_t data);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= cfg_addr_t'(addr[1:0]);
        cfg_wdata <= data[15:0];
        @(posedge clk);
        cfg_write <= 1'b0;
        // Zero rounds is stored as one
        if (addr[1:0] == 2'd0) begin
            model_rounds = (data[3:0] == 4'd0) ? 1 : int'(data[3:0]);
        end
    endtask

    task automatic read_register(input cipher_block_t addr, input cipher_block_t expected);
        @(posedge clk);
        cfg_read <= 1'b1;
        cfg_addr <= cfg_addr_t'(addr[1:0]);
        @(posedge clk);
        cfg_read <= 1'b0;
        @(negedge clk);
        check_value("cfg_rdata", 128'(cfg_rdata), 128'(expected[15:0]));
        if (addr[1:0] == 2'd2) begin
            check_value("block_count", 128'(cfg_rdata), 128'(handshakes));
        end
    endtask

    task automatic run_block(input cipher_block_t pt, input cipher_block_t k,
                             input cipher_block_t expected);
        int gap;
        int latency;
        gap = int'($urandom % 4);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        in_valid  <= 1'b1;
        plaintext <= pt;
        key       <= k;
        out_ready <= 1'b0;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        // Acceptance edge
        @(posedge clk);
        in_valid <= 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end while (!out_valid);
        check_value("latency", 128'(latency), 128'(model_rounds));
        check_value("ciphertext", ciphertext, expected);
        check_value("in_ready", 128'(in_ready), 128'd0);
        repeat (stall_cycles) begin
            @(posedge clk);
            // Another block offered under back-pressure must not enter
            in_valid  <= 1'b1;
            plaintext <= ~pt;
            key       <= ~k;
            @(negedge clk);
            check_value("out_valid", 128'(out_valid), 128'd1);
            check_value("in_ready", 128'(in_ready), 128'd0);
            check_value("ciphertext", ciphertext, expected);
        end
        stall_cycles = 0;
        @(posedge clk);
        out_ready <= 1'b1;
        // Output handshake edge
        @(posedge clk);
        out_ready <= 1'b0;
        in_valid  <= 1'b0;
        handshakes++;
        @(negedge clk);
        check_value("out_valid", 128'(out_valid), 128'd0);
        check_value("in_ready", 128'(in_ready), 128'd1);
    endtask

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        plaintext    = '0;
        key          = '0;
        out_ready    = 1'b0;
        cfg_write    = 1'b0;
        cfg_read     = 1'b0;
        cfg_addr     = cfg_rounds;
        cfg_wdata    = '0;
        error_count  = 0;
        handshakes   = 0;
        model_rounds = `CIPHER_RESET_ROUNDS;
        stall_cycles = 0;
        stim_loaded  = 1'b0;
        void'($urandom(RAND_SEED));
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("in_ready", 128'(in_ready), 128'd1);
        check_value("out_valid", 128'(out_valid), 128'd0);
        foreach (op_code[i]) begin
            case (op_code[i])
                "W": write_register(op_arg0[i], op_arg1[i]);
                "R": read_register(op_arg0[i], op_arg1[i]);
                "B": run_block(op_arg0[i], op_arg1[i], op_arg2[i]);
                // Stall applies to the next block
                "P": stall_cycles = int'(op_arg0[i][15:0]);
                default: begin
                    $display("Unknown operation in the stimulus file at entry %0d", i);
                    $display("Finished with errors");
                    $fatal(1, "Bad stimulus");
                end
            endcase
        end
        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the number of operations
    initial begin
        wait (stim_loaded);
        repeat (op_code.size() * CYCLES_PER_OP + RESET_CYCLES) @(posedge clk);
        $display("Watchdog expired before the stimulus was finished");
        $display("Finished with errors");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

//--- bench/cipher_properties.sv
// Concurrent checks on the round engine
// Handshake stability, exclusive ready and valid, nonzero round count

`timescale 1ns/10ps
`default_nettype none

module cipher_properties (
    input logic                      clk,
    input logic                      rst,
    input logic                      in_valid,
    input logic                      in_ready,
    input cipher_pkg::cipher_block_t plaintext,
    input cipher_pkg::cipher_block_t key,
    input logic                      out_valid,
    input logic                      out_ready,
    input cipher_pkg::cipher_block_t ciphertext,
    input cipher_pkg::round_count_t  rounds
);

    // Source holds its block while the engine is busy
    property input_held_p;
        @(posedge clk) disable iff (rst)
            (in_valid && !in_ready) |=> ($stable(plaintext) && $stable(key));
    endproperty

    // Result held under back-pressure
    property output_held_p;
        @(posedge clk) disable iff (rst)
            (out_valid && !out_ready) |=> $stable(ciphertext);
    endproperty

    property ready_valid_exclusive_p;
        @(posedge clk) disable iff (rst)
            !(in_ready && out_valid);
    endproperty

    property rounds_nonzero_p;
        @(posedge clk) disable iff (rst)
            rounds != '0;
    endproperty

    input_held_a: assert property (input_held_p)
        else $error("plaintext or key changed while waiting for in_ready");
    output_held_a: assert property (output_held_p)
        else $error("ciphertext changed while out_ready was low");
    ready_valid_a: assert property (ready_valid_exclusive_p)
        else $error("in_ready and out_valid were high together");
    rounds_a: assert property (rounds_nonzero_p)
        else $error("round count reached the engine as zero");

endmodule

`default_nettype wire

//--- source/cipher_top.sv
// Top level of the block cipher engine
// Configuration registers next to the iterative round engine

`timescale 1ns/10ps
`default_nettype none

module cipher_top (
    input  logic                      clk,
    input  logic                      rst,
    // Block input
    input  logic                      in_valid,
    output logic                      in_ready,
    input  cipher_pkg::cipher_block_t plaintext,
    input  cipher_pkg::cipher_block_t key,
    // Result output
    output logic                      out_valid,
    input  logic                      out_ready,
    output cipher_pkg::cipher_block_t ciphertext,
    // Configuration port
    input  logic                      cfg_write,
    input  logic                      cfg_read,
    input  cipher_pkg::cfg_addr_t     cfg_addr,
    input  cipher_pkg::cfg_word_t     cfg_wdata,
    output cipher_pkg::cfg_word_t     cfg_rdata
);

    import cipher_pkg::*;

    // Settings from the register block
    round_count_t  rounds;
    rotate_bytes_t rotate_bytes;

    // Completed handshake back to the counter
    logic          block_done;

    cipher_config u_config (
        .clk          (clk),
        .rst          (rst),
        .cfg_write    (cfg_write),
        .cfg_read     (cfg_read),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .block_done   (block_done),
        .rounds       (rounds),
        .rotate_bytes (rotate_bytes)
    );

    cipher_round_core u_core (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .plaintext    (plaintext),
        .key          (key),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .ciphertext   (ciphertext),
        .rounds       (rounds),
        .rotate_bytes (rotate_bytes),
        .block_done   (block_done)
    );

endmodule

`default_nettype wire

//--- source/cipher_round_core.sv
// Iterative round engine of the block cipher
// XOR with the round key, then a byte-wise right rotate of the key, once per cycle

`timescale 1ns/10ps
`default_nettype none

`include "cipher_cfg.svh"

module cipher_round_core (
    input  logic                      clk,
    input  logic                      rst,
    // Block input handshake
    input  logic                      in_valid,
    output logic                      in_ready,
    input  cipher_pkg::cipher_block_t plaintext,
    input  cipher_pkg::cipher_block_t key,
    // Result output handshake
    output logic                      out_valid,
    input  logic                      out_ready,
    output cipher_pkg::cipher_block_t ciphertext,
    // Settings, sampled when a block is accepted
    input  cipher_pkg::round_count_t  rounds,
    input  cipher_pkg::rotate_bytes_t rotate_bytes,
    // Completed output handshake
    output logic                      block_done
);

    import cipher_pkg::*;

    localparam int BLOCK_BITS  = `CIPHER_BLOCK_BITS;
    localparam int ROT_STAGES  = $bits(rotate_bytes_t);

    // Engine phases
    typedef enum logic [1:0] {
        phase_idle,
        phase_run,
        phase_hold
    } phase_t;

    phase_t        phase;

    // Data path
    cipher_block_t state;
    cipher_block_t round_key;
    cipher_block_t key_rotated;

    // Settings latched at acceptance
    round_count_t  rounds_q;
    rotate_bytes_t rotate_q;

    // Number of the round performed on the next edge
    round_count_t  round_cnt;

    logic          accept;
    logic          last_round;

    // Intermediate results of the rotator stages
    cipher_block_t rot_stage [0:ROT_STAGES];

    assign in_ready   = (phase == phase_idle);
    assign out_valid  = (phase == phase_hold);
    assign accept     = in_valid && in_ready;
    assign last_round = (round_cnt == rounds_q);
    assign block_done = out_valid && out_ready;

    // Result stays in the state register until it is taken
    assign ciphertext = state;

    // Logarithmic byte rotator, stage s rotates right by 2**s bytes
    assign rot_stage[0] = round_key;

    for (genvar s = 0; s < ROT_STAGES; s++) begin : g_rot
        localparam int SHIFT = 8 << s;

        assign rot_stage[s+1] = rotate_q[s]
            ? {rot_stage[s][SHIFT-1:0], rot_stage[s][BLOCK_BITS-1:SHIFT]}
            : rot_stage[s];
    end

    assign key_rotated = rot_stage[ROT_STAGES];

    // Phase control and round counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= phase_idle;
            round_cnt <= '0;
        end else begin
            case (phase)
                phase_idle: begin
                    if (accept) begin
                        phase     <= phase_run;
                        round_cnt <= round_count_t'(1);
                    end
                end
                phase_run: begin
                    // Last round and result valid on the same edge
                    if (last_round) begin
                        phase <= phase_hold;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                phase_hold: begin
                    if (out_ready) begin
                        phase <= phase_idle;
                    end
                end
                default: begin
                    phase <= phase_idle;
                end
            endcase
        end
    end

    // Settings copy, later config writes only affect the next block
    always_ff @(posedge clk) begin
        if (accept) begin
            rounds_q <= rounds;
            rotate_q <= rotate_bytes;
        end
    end

    // Block state and round key
    always_ff @(posedge clk) begin
        if (accept) begin
            state     <= plaintext;
            round_key <= key;
        end else if (phase == phase_run) begin
            state     <= state ^ round_key;
            round_key <= key_rotated;
        end
    end

endmodule

`default_nettype wire

//--- source/cipher_config.sv
// Configuration registers of the cipher engine
// Round count, rotate amount and completed-block counter behind a strobe port

`timescale 1ns/10ps
`default_nettype none

`include "cipher_cfg.svh"

module cipher_config (
    input  logic                     clk,
    input  logic                     rst,
    // Software strobe port
    input  logic                     cfg_write,
    input  logic                     cfg_read,
    input  cipher_pkg::cfg_addr_t    cfg_addr,
    input  cipher_pkg::cfg_word_t    cfg_wdata,
    output cipher_pkg::cfg_word_t    cfg_rdata,
    // From the round engine
    input  logic                     block_done,
    // Settings to the round engine
    output cipher_pkg::round_count_t rounds,
    output cipher_pkg::rotate_bytes_t rotate_bytes
);

    import cipher_pkg::*;

    localparam int ROUND_BITS  = $bits(round_count_t);
    localparam int ROTATE_BITS = $bits(rotate_bytes_t);

    // Completed blocks, wraps at 16 bits
    cfg_word_t    block_count;

    // Write field of the round register
    round_count_t wr_rounds;

    assign wr_rounds = cfg_wdata[ROUND_BITS-1:0];

    // Writable settings
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rounds       <= round_count_t'(`CIPHER_RESET_ROUNDS);
            rotate_bytes <= rotate_bytes_t'(`CIPHER_RESET_ROTATE);
        end else if (cfg_write) begin
            case (cfg_addr)
                cfg_rounds: begin
                    // Zero rounds is not a valid setting, store one instead
                    if (wr_rounds == '0) begin
                        rounds <= round_count_t'(1);
                    end else begin
                        rounds <= wr_rounds;
                    end
                end
                cfg_rotate: begin
                    rotate_bytes <= cfg_wdata[ROTATE_BITS-1:0];
                end
                default: begin
                    // Block count and unused address are read-only
                end
            endcase
        end
    end

    // One count per output handshake of the engine
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            block_count <= '0;
        end else if (block_done) begin
            block_count <= block_count + 16'd1;
        end
    end

    // Registered read data, held until the next read strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_rdata <= '0;
        end else if (cfg_read) begin
            case (cfg_addr)
                cfg_rounds: begin
                    cfg_rdata <= cfg_word_t'(rounds);
                end
                cfg_rotate: begin
                    cfg_rdata <= cfg_word_t'(rotate_bytes);
                end
                cfg_block_count: begin
                    cfg_rdata <= block_count;
                end
                default: begin
                    cfg_rdata <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/cipher_pkg.sv
// Shared types of the block cipher engine
// Block, round count, rotate amount and configuration register map

`default_nettype none

`include "cipher_cfg.svh"

package cipher_pkg;

    // One plaintext, key or ciphertext
    typedef logic [`CIPHER_BLOCK_BITS-1:0] cipher_block_t;

    // Number of rounds per block
    typedef logic [`CIPHER_ROUND_BITS-1:0] round_count_t;

    // Rotate amount in whole bytes, 0 up to one less than the block size
    typedef logic [$clog2(`CIPHER_BLOCK_BITS/8)-1:0] rotate_bytes_t;

    // Configuration register addresses
    typedef enum logic [1:0] {
        cfg_rounds      = 2'd0,
        cfg_rotate      = 2'd1,
        // Read-only
        cfg_block_count = 2'd2
    } cfg_addr_t;

    // Configuration data word
    typedef logic [15:0] cfg_word_t;

endpackage

`default_nettype wire

//--- include/cipher_cfg.svh
// Build-time settings of the block cipher engine
// Block width, round-count width and register reset values

`ifndef CIPHER_CFG_SVH
`define CIPHER_CFG_SVH

// Width of one plaintext, key or ciphertext block
`define CIPHER_BLOCK_BITS 128

// Width of the round count, counts run from 1 to 15
`define CIPHER_ROUND_BITS 4

// Round count after reset
`define CIPHER_RESET_ROUNDS 8

// Rotate amount after reset, in bytes (16-bit rotate)
`define CIPHER_RESET_ROTATE 2

`endif
